// File: design/mwc_pkg.sv
/*
  Shared widths, tuple field positions and encodings for the memory write controller.
  Storage pointer is manager id over local address; the local address splits into
  channel, bank, page and word from the top down. fifo_depth must be a power of two.
*/

package mwc_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int data_w   = 64;
  localparam int mgr_id_w = 6;
  localparam int ptr_w    = 24;
  localparam int loc_w    = ptr_w - mgr_id_w;
  localparam int opt_w    = 4;

  // dram split of the local address
  localparam int chan_w = 2;
  localparam int bank_w = 3;
  localparam int page_w = 8;
  localparam int word_w = 5;

  // ------------------------------------------------------------
  // tuple cycle layout
  // ------------------------------------------------------------
  localparam int opt0_lsb = 60;
  localparam int opt1_lsb = 56;
  localparam int val0_lsb = 24;
  localparam int val1_lsb = 0;

  // ingress queue sizing
  localparam int fifo_depth = 8;
  localparam int fifo_afull = 6;
  localparam int fifo_idx_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  // ------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------
  // bit 0 marks a start, bit 1 marks an end
  typedef enum logic [1:0] {
    mom     = 2'b00,
    som     = 2'b01,
    eom     = 2'b10,
    som_eom = 2'b11
  } cntl_e;

  typedef enum logic [1:0] {
    tuples = 2'd0,
    data   = 2'd1
  } ptype_e;

  typedef enum logic [opt_w-1:0] {
    none   = 4'd0,
    memory = 4'd1,
    other  = 4'd2
  } opt_e;

  typedef enum logic [2:0] {
    idle,
    head,
    slot0,
    slot1,
    pop,
    drain
  } ext_state_e;

endpackage

// File: design/mwc_ingress_fifo.sv
/*
  Ingress queue for one packet source. ready works as a credit: it is registered
  and drops at fifo_afull, so a source that sampled ready high may still write.
  Writes are not checked against a full queue.
*/

`timescale 1ns/1ns

module mwc_ingress_fifo
  import mwc_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // source side
  input  logic              valid,
  input  cntl_e             cntl,
  input  ptype_e            ptype,
  input  logic [data_w-1:0] data,
  output logic              ready,
  // extractor side
  input  logic              pop,
  output logic              head_valid,
  output cntl_e             head_cntl,
  output ptype_e            head_ptype,
  output logic [data_w-1:0] head_data
);

  cntl_e             mem_cntl  [fifo_depth];
  ptype_e            mem_ptype [fifo_depth];
  logic [data_w-1:0] mem_data  [fifo_depth];

  logic [fifo_idx_w-1:0] wr_ptr;
  logic [fifo_idx_w-1:0] rd_ptr;
  logic [fifo_cnt_w-1:0] count;
  logic [fifo_cnt_w-1:0] count_n;
  logic                  rd;

  assign rd = pop && head_valid;

  always_comb
  begin
    case ({valid, rd})
      2'b10:   count_n = count + 1'b1;
      2'b01:   count_n = count - 1'b1;
      default: count_n = count;
    endcase
  end

  // ------------------------------------------------------------
  // pointers, occupancy and the registered ready
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ready  <= 1'b0;
    end
    else
    begin
      if (valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count_n;
      // two entries of slack cover the one cycle lag
      ready <= (count_n < fifo_afull);
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (valid)
    begin
      mem_cntl[wr_ptr]  <= cntl;
      mem_ptype[wr_ptr] <= ptype;
      mem_data[wr_ptr]  <= data;
    end
  end

  assign head_valid = (count != '0);
  assign head_cntl  = mem_cntl[rd_ptr];
  assign head_ptype = mem_ptype[rd_ptr];
  assign head_data  = mem_data[rd_ptr];

endmodule

// File: design/mwc_desc_extract.sv
/*
  Picks a source at each packet boundary, noc first, and holds it to the end cycle.
  Tuple cycles are checked slot by slot; a slot is kept only when its option is
  memory and its pointer carries this manager's id. Data packets are discarded.
*/

`timescale 1ns/1ns

module mwc_desc_extract
  import mwc_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [mgr_id_w-1:0] mgr_id,
  // noc queue head
  input  logic                noc_head_valid,
  input  cntl_e               noc_head_cntl,
  input  ptype_e              noc_head_ptype,
  input  logic [data_w-1:0]   noc_head_data,
  // rdp queue head
  input  logic                rdp_head_valid,
  input  cntl_e               rdp_head_cntl,
  input  ptype_e              rdp_head_ptype,
  input  logic [data_w-1:0]   rdp_head_data,
  output logic                noc_pop,
  output logic                rdp_pop,
  // request generator
  output logic                push,
  output logic [ptr_w-1:0]    push_ptr,
  input  logic                full
);

  ext_state_e state;
  ext_state_e state_n;
  logic       sel_rdp;
  logic       sel_rdp_n;

  // head of the selected source
  logic              h_valid;
  cntl_e             h_cntl;
  ptype_e            h_ptype;
  logic [data_w-1:0] h_data;
  logic              h_last;

  logic [ptr_w-1:0] ptr0;
  logic [ptr_w-1:0] ptr1;
  logic             want0;
  logic             want1;
  logic             pop_now;

  assign h_valid = sel_rdp ? rdp_head_valid : noc_head_valid;
  assign h_cntl  = sel_rdp ? rdp_head_cntl  : noc_head_cntl;
  assign h_ptype = sel_rdp ? rdp_head_ptype : noc_head_ptype;
  assign h_data  = sel_rdp ? rdp_head_data  : noc_head_data;
  assign h_last  = (h_cntl == eom) || (h_cntl == som_eom);

  // ------------------------------------------------------------
  // slot decode
  // ------------------------------------------------------------
  assign ptr0 = h_data[val0_lsb +: ptr_w];
  assign ptr1 = h_data[val1_lsb +: ptr_w];

  // each slot is judged on its own option only
  assign want0 = (h_data[opt0_lsb +: opt_w] == memory) &&
                 (ptr0[loc_w +: mgr_id_w] == mgr_id);
  assign want1 = (h_data[opt1_lsb +: opt_w] == memory) &&
                 (ptr1[loc_w +: mgr_id_w] == mgr_id);

  // ------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------
  always_comb
  begin
    state_n   = state;
    sel_rdp_n = sel_rdp;
    case (state)
      idle:
      begin
        if (noc_head_valid)
        begin
          sel_rdp_n = 1'b0;
          state_n   = head;
        end
        else if (rdp_head_valid)
        begin
          sel_rdp_n = 1'b1;
          state_n   = head;
        end
      end
      head:
      begin
        // next cycle of the packet may not have arrived yet
        if (h_valid)
        begin
          if (h_ptype == tuples)
            state_n = slot0;
          else if (h_ptype == data)
            state_n = drain;
          else
            state_n = pop;
        end
      end
      slot0:
      begin
        if (!(want0 && full))
          state_n = slot1;
      end
      slot1:
      begin
        if (!(want1 && full))
          state_n = pop;
      end
      pop:
        state_n = h_last ? idle : head;
      drain:
      begin
        if (h_valid && h_last)
          state_n = idle;
      end
      default:
        state_n = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= idle;
      sel_rdp <= 1'b0;
    end
    else
    begin
      state   <= state_n;
      sel_rdp <= sel_rdp_n;
    end
  end

  // outputs
  assign push = ((state == slot0) && want0 && !full) ||
                ((state == slot1) && want1 && !full);
  assign push_ptr = (state == slot1) ? ptr1 : ptr0;

  // drain pops one data cycle per clock while the head is there
  assign pop_now = (state == pop) || ((state == drain) && h_valid);
  assign noc_pop = pop_now && !sel_rdp;
  assign rdp_pop = pop_now && sel_rdp;

endmodule

// File: design/mwc_request_gen.sv
/*
  Two-entry pointer queue in front of the memory port. Only the local address is
  kept; the manager id was already matched upstream. A push while full is not
  accepted by the caller, so it is not checked here.
*/

`timescale 1ns/1ns

module mwc_request_gen
  import mwc_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  logic [ptr_w-1:0]  push_ptr,
  output logic              full,
  // memory request port
  output logic              mem_valid,
  output logic [chan_w-1:0] mem_channel,
  output logic [bank_w-1:0] mem_bank,
  output logic [page_w-1:0] mem_page,
  output logic [word_w-1:0] mem_word,
  input  logic              mem_ready
);

  // q0 is the oldest and is the one on the port
  logic [loc_w-1:0] q0;
  logic [loc_w-1:0] q1;
  logic [1:0]       count;
  logic             xfer;

  assign xfer = mem_valid && mem_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      count <= 2'd0;
    else if (push && !xfer)
      count <= count + 2'd1;
    else if (xfer && !push)
      count <= count - 2'd1;
  end

  // entry moves
  always_ff @(posedge clk)
  begin
    if (push && (count == 2'd0 || (xfer && count == 2'd1)))
      q0 <= push_ptr[loc_w-1:0];
    else if (xfer)
      q0 <= q1;

    if (push && ((count == 2'd1 && !xfer) || count == 2'd2))
      q1 <= push_ptr[loc_w-1:0];
  end

  assign full      = (count == 2'd2);
  assign mem_valid = (count != 2'd0);

  // channel, bank, page, word from the top of the local address
  assign {mem_channel, mem_bank, mem_page, mem_word} = q0;

endmodule

// File: design/mwc_top.sv
/*
  Memory write controller of one manager. Both sources follow the ready-as-credit
  rule; memory requests hold until mem_ready. Latency from input to request varies.
*/

`timescale 1ns/1ns

module mwc_top
  import mwc_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [mgr_id_w-1:0] mgr_id,
  // noc source
  input  logic                noc_valid,
  input  cntl_e               noc_cntl,
  input  ptype_e              noc_ptype,
  input  logic [data_w-1:0]   noc_data,
  output logic                noc_ready,
  // rdp source
  input  logic                rdp_valid,
  input  cntl_e               rdp_cntl,
  input  ptype_e              rdp_ptype,
  input  logic [data_w-1:0]   rdp_data,
  output logic                rdp_ready,
  // memory
  output logic                mem_valid,
  output logic [chan_w-1:0]   mem_channel,
  output logic [bank_w-1:0]   mem_bank,
  output logic [page_w-1:0]   mem_page,
  output logic [word_w-1:0]   mem_word,
  input  logic                mem_ready
);

  logic              noc_head_valid;
  cntl_e             noc_head_cntl;
  ptype_e            noc_head_ptype;
  logic [data_w-1:0] noc_head_data;
  logic              noc_pop;

  logic              rdp_head_valid;
  cntl_e             rdp_head_cntl;
  ptype_e            rdp_head_ptype;
  logic [data_w-1:0] rdp_head_data;
  logic              rdp_pop;

  logic              push;
  logic [ptr_w-1:0]  push_ptr;
  logic              full;

  // ------------------------------------------------------------
  // ingress queues
  // ------------------------------------------------------------
  mwc_ingress_fifo u_noc_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid      (noc_valid),
    .cntl       (noc_cntl),
    .ptype      (noc_ptype),
    .data       (noc_data),
    .ready      (noc_ready),
    .pop        (noc_pop),
    .head_valid (noc_head_valid),
    .head_cntl  (noc_head_cntl),
    .head_ptype (noc_head_ptype),
    .head_data  (noc_head_data)
  );

  mwc_ingress_fifo u_rdp_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid      (rdp_valid),
    .cntl       (rdp_cntl),
    .ptype      (rdp_ptype),
    .data       (rdp_data),
    .ready      (rdp_ready),
    .pop        (rdp_pop),
    .head_valid (rdp_head_valid),
    .head_cntl  (rdp_head_cntl),
    .head_ptype (rdp_head_ptype),
    .head_data  (rdp_head_data)
  );

  // ------------------------------------------------------------
  // descriptor extraction and requests
  // ------------------------------------------------------------
  mwc_desc_extract u_extract (
    .clk            (clk),
    .rst_n          (rst_n),
    .mgr_id         (mgr_id),
    .noc_head_valid (noc_head_valid),
    .noc_head_cntl  (noc_head_cntl),
    .noc_head_ptype (noc_head_ptype),
    .noc_head_data  (noc_head_data),
    .rdp_head_valid (rdp_head_valid),
    .rdp_head_cntl  (rdp_head_cntl),
    .rdp_head_ptype (rdp_head_ptype),
    .rdp_head_data  (rdp_head_data),
    .noc_pop        (noc_pop),
    .rdp_pop        (rdp_pop),
    .push           (push),
    .push_ptr       (push_ptr),
    .full           (full)
  );

  mwc_request_gen u_req (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (push),
    .push_ptr    (push_ptr),
    .full        (full),
    .mem_valid   (mem_valid),
    .mem_channel (mem_channel),
    .mem_bank    (mem_bank),
    .mem_page    (mem_page),
    .mem_word    (mem_word),
    .mem_ready   (mem_ready)
  );

endmodule

// File: tests/mwc_chk.sv
/*
  Protocol assertions bound into mwc_top. Sources must honour the registered
  ready; a request holds while stalled and mem_valid stays low in reset.
*/

`timescale 1ns/1ns

module mwc_chk
  import mwc_pkg::*;
(
  input logic              clk,
  input logic              rst_n,
  input logic              noc_valid,
  input logic              noc_ready,
  input logic              rdp_valid,
  input logic              rdp_ready,
  input logic              mem_valid,
  input logic              mem_ready,
  input logic [chan_w-1:0] mem_channel,
  input logic [bank_w-1:0] mem_bank,
  input logic [page_w-1:0] mem_page,
  input logic [word_w-1:0] mem_word
);

  logic [loc_w-1:0] req_fields;
  // failed assertions, read by the testbench
  int               fails = 0;

  assign req_fields = {mem_channel, mem_bank, mem_page, mem_word};

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(req_fields))
    else
    begin
      fails++;
      $error("memory request dropped or changed before its transfer");
    end

  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !mem_valid)
    else
    begin
      fails++;
      $error("mem_valid high during reset");
    end

  // a source cycle only after ready was seen high
  a_noc_credit: assert property (@(posedge clk) disable iff (!rst_n)
    noc_valid |-> noc_ready)
    else
    begin
      fails++;
      $error("noc cycle written while noc_ready was low");
    end

  a_rdp_credit: assert property (@(posedge clk) disable iff (!rst_n)
    rdp_valid |-> rdp_ready)
    else
    begin
      fails++;
      $error("rdp cycle written while rdp_ready was low");
    end

endmodule

bind mwc_top mwc_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .noc_valid   (noc_valid),
  .noc_ready   (noc_ready),
  .rdp_valid   (rdp_valid),
  .rdp_ready   (rdp_ready),
  .mem_valid   (mem_valid),
  .mem_ready   (mem_ready),
  .mem_channel (mem_channel),
  .mem_bank    (mem_bank),
  .mem_page    (mem_page),
  .mem_word    (mem_word)
);

// File: tests/mwc_monitor.sv
/*
  Memory port checker. The exp lines of the stimulus file are the requests in
  order. The port is sampled on the falling edge, where it is stable.
  Each source's ready must also fall at least once under the long bursts.
*/

`timescale 1ns/1ns

module mwc_monitor
  import mwc_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              noc_ready,
  input  logic              rdp_ready,
  input  logic              mem_valid,
  input  logic              mem_ready,
  input  logic [chan_w-1:0] mem_channel,
  input  logic [bank_w-1:0] mem_bank,
  input  logic [page_w-1:0] mem_page,
  input  logic [word_w-1:0] mem_word,
  input  logic              end_of_test,
  output logic              all_seen,
  output int                errors
);

  // expected fields packed as channel, bank, page, word
  logic [loc_w-1:0] exp_q[$];
  int               exp_total = 0;
  int               got = 0;
  int               cmp_errors = 0;
  int               end_errors = 0;
  logic             load_failed = 1'b0;

  // high-to-low steps of each source's ready
  int               noc_drops = 0;
  int               rdp_drops = 0;
  logic             noc_ready_q = 1'b0;
  logic             rdp_ready_q = 1'b0;

  initial
  begin : load_expected
    integer            fd;
    integer            r;
    logic [63:0]       tag;
    logic [1023:0]     rest;
    logic [chan_w-1:0] c;
    logic [bank_w-1:0] b;
    logic [page_w-1:0] p;
    logic [word_w-1:0] w;
    fd = $fopen("tests/mwc_stimulus.txt", "r");
    if (fd == 0)
      load_failed = 1'b1;
    else
    begin
      while ($fscanf(fd, "%s", tag) == 1)
      begin
        if (tag == "exp")
        begin
          r = $fscanf(fd, "%h %h %h %h", c, b, p, w);
          exp_q.push_back({c, b, p, w});
        end
        else
          r = $fgets(rest, fd);
      end
      $fclose(fd);
    end
    exp_total = exp_q.size();
  end

  task automatic compare_field(input string name, input int expected, input int actual);
    if (expected != actual)
    begin
      $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
      cmp_errors++;
    end
  endtask

  // ------------------------------------------------------------
  // one check per transfer
  // ------------------------------------------------------------
  always @(negedge clk)
  begin : watch_port
    logic [chan_w-1:0] ec;
    logic [bank_w-1:0] eb;
    logic [page_w-1:0] ep;
    logic [word_w-1:0] ew;
    if (rst_n && mem_valid && mem_ready)
    begin
      if (got >= exp_total)
      begin
        $display("unexpected request at %0t ns beyond the %0d expected", $time, exp_total);
        cmp_errors++;
      end
      else
      begin
        {ec, eb, ep, ew} = exp_q[got];
        compare_field("mem_channel", ec, mem_channel);
        compare_field("mem_bank", eb, mem_bank);
        compare_field("mem_page", ep, mem_page);
        compare_field("mem_word", ew, mem_word);
      end
      got++;
    end
  end

  // source ready falls once a queue reaches fifo_afull
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (noc_ready_q && !noc_ready)
        noc_drops++;
      if (rdp_ready_q && !rdp_ready)
        rdp_drops++;
      noc_ready_q = noc_ready;
      rdp_ready_q = rdp_ready;
    end
  end

  always @(posedge end_of_test)
  begin
    if (load_failed)
    begin
      $display("monitor could not open the stimulus file");
      end_errors++;
    end
    if (got < exp_total)
    begin
      $display("%0d of %0d expected requests never arrived", exp_total - got, exp_total);
      end_errors++;
    end
    if (noc_drops == 0)
    begin
      $display("noc_ready never dropped while the noc queue filled");
      end_errors++;
    end
    if (rdp_drops == 0)
    begin
      $display("rdp_ready never dropped while the rdp queue filled");
      end_errors++;
    end
  end

  assign all_seen = (got >= exp_total);
  assign errors   = cmp_errors + end_errors;

endmodule

// File: tests/tb_mwc.sv
/*
  Testbench for the memory write controller. Manager id, source cycles and the
  expected requests come from tests/mwc_stimulus.txt. Back-pressure uses $random.
*/

`timescale 1ns/1ns

module tb_mwc
  import mwc_pkg::*;
();

  localparam string stim_file = "tests/mwc_stimulus.txt";

  logic                clk;
  logic                rst_n;
  logic [mgr_id_w-1:0] mgr_id;
  logic                noc_valid;
  cntl_e               noc_cntl;
  ptype_e              noc_ptype;
  logic [data_w-1:0]   noc_data;
  logic                noc_ready;
  logic                rdp_valid;
  cntl_e               rdp_cntl;
  ptype_e              rdp_ptype;
  logic [data_w-1:0]   rdp_data;
  logic                rdp_ready;
  logic                mem_valid;
  logic [chan_w-1:0]   mem_channel;
  logic [bank_w-1:0]   mem_bank;
  logic [page_w-1:0]   mem_page;
  logic [word_w-1:0]   mem_word;
  logic                mem_ready;

  logic                end_of_test;
  logic                all_seen;
  int                  mon_errors;
  int                  tb_errors;
  int                  line_count;
  logic                load_done;
  integer              seed;
  logic [mgr_id_w-1:0] mgr_val;

  // entry: [68] paired start marker, [67:66] cntl, [65:64] ptype, [63:0] data
  logic [68:0] noc_q[$];
  logic [68:0] rdp_q[$];

  mwc_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .mgr_id      (mgr_id),
    .noc_valid   (noc_valid),
    .noc_cntl    (noc_cntl),
    .noc_ptype   (noc_ptype),
    .noc_data    (noc_data),
    .noc_ready   (noc_ready),
    .rdp_valid   (rdp_valid),
    .rdp_cntl    (rdp_cntl),
    .rdp_ptype   (rdp_ptype),
    .rdp_data    (rdp_data),
    .rdp_ready   (rdp_ready),
    .mem_valid   (mem_valid),
    .mem_channel (mem_channel),
    .mem_bank    (mem_bank),
    .mem_page    (mem_page),
    .mem_word    (mem_word),
    .mem_ready   (mem_ready)
  );

  mwc_monitor u_mon (
    .clk         (clk),
    .rst_n       (rst_n),
    .noc_ready   (noc_ready),
    .rdp_ready   (rdp_ready),
    .mem_valid   (mem_valid),
    .mem_ready   (mem_ready),
    .mem_channel (mem_channel),
    .mem_bank    (mem_bank),
    .mem_page    (mem_page),
    .mem_word    (mem_word),
    .end_of_test (end_of_test),
    .all_seen    (all_seen),
    .errors      (mon_errors)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ------------------------------------------------------------
  // stimulus file
  // ------------------------------------------------------------
  task automatic load_stimulus();
    integer            fd;
    integer            r;
    logic [63:0]       tag;
    logic [1023:0]     rest;
    logic [1:0]        c;
    logic [1:0]        p;
    logic [data_w-1:0] d;
    fd = $fopen(stim_file, "r");
    if (fd == 0)
    begin
      $display("could not open %s", stim_file);
      tb_errors++;
    end
    else
    begin
      while ($fscanf(fd, "%s", tag) == 1)
      begin
        line_count++;
        case (tag)
          "#":   r = $fgets(rest, fd);
          "exp": r = $fgets(rest, fd);
          "mgr": r = $fscanf(fd, "%h", mgr_val);
          "noc":
          begin
            r = $fscanf(fd, "%d %d %h", c, p, d);
            noc_q.push_back({1'b0, c, p, d});
          end
          "rdp":
          begin
            r = $fscanf(fd, "%d %d %h", c, p, d);
            rdp_q.push_back({1'b0, c, p, d});
          end
          "both":
          begin
            noc_q.push_back({1'b1, 68'd0});
            rdp_q.push_back({1'b1, 68'd0});
          end
          default:
          begin
            $display("unknown tag %0s in the stimulus file", tag);
            tb_errors++;
            r = $fgets(rest, fd);
          end
        endcase
      end
      $fclose(fd);
      load_done = 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // source driving, one step per clock
  // ------------------------------------------------------------
  task automatic drive_sources();
    logic [68:0] e;
    noc_valid = 1'b0;
    rdp_valid = 1'b0;
    // paired markers release both sources on the same edge
    if (noc_q.size() > 0 && rdp_q.size() > 0 && noc_q[0][68] && rdp_q[0][68] &&
        noc_ready && rdp_ready)
    begin
      e = noc_q.pop_front();
      e = rdp_q.pop_front();
    end
    if (noc_q.size() > 0 && !noc_q[0][68] && noc_ready)
    begin
      e = noc_q.pop_front();
      noc_valid = 1'b1;
      noc_cntl  = cntl_e'(e[67:66]);
      noc_ptype = ptype_e'(e[65:64]);
      noc_data  = e[63:0];
    end
    if (rdp_q.size() > 0 && !rdp_q[0][68] && rdp_ready)
    begin
      e = rdp_q.pop_front();
      rdp_valid = 1'b1;
      rdp_cntl  = cntl_e'(e[67:66]);
      rdp_ptype = ptype_e'(e[65:64]);
      rdp_data  = e[63:0];
    end
  endtask

  task automatic close_run();
    end_of_test = 1'b1;
    #1;
    $display("errors: monitor %0d, assertions %0d, testbench %0d",
             mon_errors, u_dut.u_chk.fails, tb_errors);
    if (mon_errors == 0 && u_dut.u_chk.fails == 0 && tb_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // random memory back-pressure, ready about two cycles in three
  always @(posedge clk)
  begin
    #1;
    mem_ready = rst_n && (($random(seed) % 3) != 0);
  end

  initial
  begin
    seed        = 53;
    rst_n       = 1'b0;
    mgr_id      = '0;
    noc_valid   = 1'b0;
    noc_cntl    = mom;
    noc_ptype   = tuples;
    noc_data    = '0;
    rdp_valid   = 1'b0;
    rdp_cntl    = mom;
    rdp_ptype   = tuples;
    rdp_data    = '0;
    mem_ready   = 1'b0;
    end_of_test = 1'b0;
    tb_errors   = 0;
    line_count  = 0;
    load_done   = 1'b0;
    mgr_val     = '0;
    load_stimulus();
    if (!load_done)
      close_run();
    else
    begin
      mgr_id = mgr_val;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      while (noc_q.size() > 0 || rdp_q.size() > 0)
      begin
        @(posedge clk);
        #1;
        drive_sources();
      end
      @(posedge clk);
      #1;
      noc_valid = 1'b0;
      rdp_valid = 1'b0;
      wait (all_seen);
      // idle time to catch any extra request
      repeat (20) @(posedge clk);
      close_run();
    end
  end

  // watchdog, 40 cycles per stimulus line
  initial
  begin
    wait (load_done);
    repeat (40 * line_count) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", 40 * line_count);
    tb_errors++;
    close_run();
  end

endmodule

// File: tests/mwc_stimulus.txt
# noc|rdp cntl(0 mom 1 som 2 eom 3 som_eom) ptype(0 tuples 1 data) data(hex)
# mgr id(hex), both = sources start together, exp channel bank page word (hex)
mgr 2a
# filtering: local memory, other id, none and other options
noc 1 0 1100A94685540123
noc 2 0 0200A80001A80002
# two pointers in one cycle
noc 3 0 1100A82021ABFFFF
# data packet, then a tuple packet
noc 1 1 DEADBEEF00000001
noc 2 1 1100A80000A80000
noc 3 0 1000AA0200000000
rdp 1 1 0123456789ABCDEF
rdp 0 1 1100A8FFFFA8FFFF
rdp 2 1 FFFFFFFFFFFFFFFF
# long noc burst
noc 1 0 1100A90800AA1000
noc 0 0 1100A92821AA3021
noc 0 0 1100A94842AA5042
noc 0 0 1100A96863AA7063
noc 0 0 1100A98884AA9084
noc 2 0 1100A9A8A5AAB0A5
# priority, then a long rdp burst
both
noc 3 0 1100A9C8C6AAD0C6
rdp 1 0 1100AB1800540123
rdp 0 0 1100AB3821540123
rdp 0 0 1100AB5842540123
rdp 0 0 1100AB7863540123
rdp 0 0 1100AB9884540123
rdp 2 0 1100ABB8A5540123
exp 1 2 34 05
exp 0 1 01 01
exp 3 7 ff 1f
exp 2 0 10 00
exp 1 0 40 00
exp 2 0 80 00
exp 1 1 41 01
exp 2 1 81 01
exp 1 2 42 02
exp 2 2 82 02
exp 1 3 43 03
exp 2 3 83 03
exp 1 4 44 04
exp 2 4 84 04
exp 1 5 45 05
exp 2 5 85 05
exp 1 6 46 06
exp 2 6 86 06
exp 3 0 c0 00
exp 3 1 c1 01
exp 3 2 c2 02
exp 3 3 c3 03
exp 3 4 c4 04
exp 3 5 c5 05

// File: compile.f
design/mwc_pkg.sv
design/mwc_ingress_fifo.sv
design/mwc_desc_extract.sv
design/mwc_request_gen.sv
design/mwc_top.sv
tests/mwc_chk.sv
tests/mwc_monitor.sv
tests/tb_mwc.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the memory write controller testbench with Verilator and runs it.
# The run passes only when the pass line appears in the simulation output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_mwc \
    -f compile.f -o sim_mwc; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_mwc)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
  exit 0
fi
echo "pass line not found in the simulation output"
exit 1
